// File: logic/sort_settings.svh
`ifndef SORT_SETTINGS_SVH
`define SORT_SETTINGS_SVH

//////////////////////////////
// list geometry
//////////////////////////////

`define COORD_W 8 //bits per coordinate
`define COST_W 16 //start plus goal total
`define OPEN_DEPTH 16 //open list entries

//////////////////////////////
// flow control and weights
//////////////////////////////

`define OUT_CREDITS 4 //downstream credits after reset
`define STRAIGHT_W 10 //straight step
`define DIAG_W 14 //diagonal step, 10 x root two

`endif

// File: logic/grid_pkg.sv
`include "sort_settings.svh"

package grid_pkg;

	//////////////////////////////
	// grid and list types
	//////////////////////////////

	// one grid coordinate
	typedef logic [`COORD_W-1:0] coord_t;

	// total octile cost of a node
	typedef logic [`COST_W-1:0] cost_t;

	// position inside the open list
	typedef logic [$clog2(`OPEN_DEPTH)-1:0] idx_t;

	// number of entries, one bit wider so a full list fits
	typedef logic [$clog2(`OPEN_DEPTH):0] count_t;

endpackage

// File: logic/sort_ctrl_pkg.sv
package sort_ctrl_pkg;

	typedef enum logic [2:0] {
		IDLE, //issue credits, wait for first node
		LOAD, //rest of the batch
		FETCH, //pair read, costs computed
		COMPARE,
		SWAP,
		NEXT, //step index or end pass
		DRAIN
	} sort_state_t;

	typedef enum logic [2:0] {
		HOLD,
		CLEAR, //length and both indices
		INC_LEN,
		INC_IDX,
		CLR_IDX, //restart pass
		INC_OUT
	} cnt_op_t;

endpackage

// File: logic/sort_fsm.sv
`timescale 1ns/10ps
`include "sort_settings.svh"

module sort_fsm import grid_pkg::*, sort_ctrl_pkg::*;
(
	input  logic        Clk,
	input  logic        Reset,
	input  logic        node_valid,
	input  logic        node_last,
	input  logic        out_credit,
	input  count_t      len,
	input  idx_t        idx,
	input  cost_t       cost_a,
	input  cost_t       cost_b,
	input  logic        last_pair,
	input  logic        drain_end,
	output logic        in_credit,
	output logic        wr_en,
	output logic        swap_en,
	output logic        read_drain,
	output logic        out_valid,
	output logic        out_last,
	output logic        busy,
	output cnt_op_t     cnt_op
);

	localparam int OUT_CW = $clog2(`OUT_CREDITS + 1);

	sort_state_t state;
	sort_state_t next_state;
	count_t in_cnt; //credits held upstream
	logic [OUT_CW-1:0] out_cnt;
	logic pass_swap;
	logic drain_ready; //drain regs match out_idx
	logic load_state;
	logic accept;
	logic issue;

	assign load_state = (state == IDLE) || (state == LOAD);
	assign accept = load_state && node_valid;
	assign issue = load_state && !(accept && node_last)
		&& ((in_cnt + len) < count_t'(`OPEN_DEPTH)); //held plus stored fits the list

	assign wr_en = accept;
	assign swap_en = (state == SWAP);
	assign read_drain = (state == DRAIN);
	assign out_valid = read_drain && drain_ready && (out_cnt != '0);
	assign out_last = out_valid && drain_end;
	assign busy = (state != IDLE) || accept;

	//////////////////////////////
	// next state and counter op
	//////////////////////////////

	always_comb
	begin
		next_state = state;
		cnt_op = HOLD;
		case (state)
			IDLE, LOAD:
			begin
				if (accept)
				begin
					cnt_op = INC_LEN;
					if (node_last)
						next_state = (len == '0) ? DRAIN : FETCH; //single entry skips sort
					else
						next_state = LOAD;
				end
			end
			FETCH:
				next_state = COMPARE;
			COMPARE:
				next_state = (cost_a > cost_b) ? SWAP : NEXT; //strict, ties stay put
			SWAP:
				next_state = NEXT;
			NEXT:
			begin
				if (!last_pair)
				begin
					cnt_op = INC_IDX;
					next_state = FETCH;
				end
				else if (pass_swap)
				begin
					cnt_op = CLR_IDX;
					next_state = FETCH;
				end
				else
					next_state = DRAIN; //clean pass, list sorted
			end
			DRAIN:
			begin
				if (out_valid)
				begin
					if (drain_end)
					begin
						cnt_op = CLEAR;
						next_state = IDLE;
					end
					else
						cnt_op = INC_OUT;
				end
			end
			default:
				next_state = IDLE;
		endcase
	end

	//////////////////////////////
	// state, credits, pass flag
	//////////////////////////////

	always_ff @(posedge Clk or posedge Reset)
	begin
		if (Reset)
		begin
			state <= IDLE;
			in_cnt <= '0;
			in_credit <= 1'b0;
			out_cnt <= OUT_CW'(`OUT_CREDITS);
			pass_swap <= 1'b0;
			drain_ready <= 1'b0;
		end
		else
		begin
			state <= next_state;
			in_credit <= issue;
			in_cnt <= in_cnt + count_t'(issue) - count_t'(accept);
			out_cnt <= out_cnt + OUT_CW'(out_credit) - OUT_CW'(out_valid);
			drain_ready <= read_drain && !out_valid; //one cycle to refill after a step
			if (state == SWAP)
				pass_swap <= 1'b1;
			else if ((state == FETCH) && (idx == '0))
				pass_swap <= 1'b0; //new pass
		end
	end

endmodule

// File: logic/index_counter.sv
`timescale 1ns/10ps

module index_counter import grid_pkg::*, sort_ctrl_pkg::*;
(
	input  logic    Clk,
	input  logic    Reset,
	input  cnt_op_t op,
	output count_t  len,
	output idx_t    idx,
	output idx_t    out_idx,
	output logic    last_pair,
	output logic    drain_end
);

	always_ff @(posedge Clk or posedge Reset)
	begin
		if (Reset)
		begin
			len <= '0;
			idx <= '0;
			out_idx <= '0;
		end
		else
		begin
			case (op)
				CLEAR:
				begin
					len <= '0;
					idx <= '0;
					out_idx <= '0;
				end
				INC_LEN:
					len <= len + count_t'(1);
				INC_IDX:
					idx <= idx + idx_t'(1);
				CLR_IDX:
					idx <= '0;
				INC_OUT:
					out_idx <= out_idx + idx_t'(1);
				default:
				begin
					len <= len; //hold
				end
			endcase
		end
	end

	// pair at idx is the last one when idx reaches len-2
	assign last_pair = (count_t'(idx) + count_t'(2)) >= len;
	assign drain_end = (count_t'(out_idx) + count_t'(1)) == len;

endmodule

// File: logic/open_list_ram.sv
`timescale 1ns/10ps
`include "sort_settings.svh"

module open_list_ram import grid_pkg::*;
#(
	parameter int DEPTH = `OPEN_DEPTH
)
(
	input  logic   Clk,
	input  logic   Reset,
	input  logic   wr_en,
	input  logic   swap_en,
	input  logic   read_drain,
	input  idx_t   wr_idx,
	input  idx_t   pair_idx,
	input  idx_t   out_idx,
	input  coord_t wr_x,
	input  coord_t wr_y,
	output coord_t a_x,
	output coord_t a_y,
	output coord_t b_x,
	output coord_t b_y,
	output coord_t rd_x,
	output coord_t rd_y
);

	coord_t mem_x [DEPTH]; //open list x
	coord_t mem_y [DEPTH]; //open list y
	idx_t a_idx;
	idx_t b_idx;

	assign a_idx = read_drain ? out_idx : pair_idx; //cost unit scores drain entry
	assign b_idx = pair_idx + idx_t'(1);

	//////////////////////////////
	// load and swap
	//////////////////////////////

	always_ff @(posedge Clk)
	begin
		if (wr_en)
		begin
			mem_x[wr_idx] <= wr_x;
			mem_y[wr_idx] <= wr_y;
		end
		else if (swap_en)
		begin
			mem_x[pair_idx] <= mem_x[b_idx];
			mem_y[pair_idx] <= mem_y[b_idx];
			mem_x[b_idx] <= mem_x[pair_idx];
			mem_y[b_idx] <= mem_y[pair_idx];
		end
	end

	//////////////////////////////
	// read ports
	//////////////////////////////

	assign a_x = mem_x[a_idx];
	assign a_y = mem_y[a_idx];
	assign b_x = mem_x[b_idx];
	assign b_y = mem_y[b_idx];

	// registered so drain coordinates line up with the cost
	always_ff @(posedge Clk or posedge Reset)
	begin
		if (Reset)
		begin
			rd_x <= '0;
			rd_y <= '0;
		end
		else
		begin
			rd_x <= mem_x[out_idx];
			rd_y <= mem_y[out_idx];
		end
	end

endmodule

// File: logic/octile_cost.sv
`timescale 1ns/10ps
`include "sort_settings.svh"

module octile_cost import grid_pkg::*;
(
	input  logic   Clk,
	input  logic   Reset,
	input  coord_t a_x,
	input  coord_t a_y,
	input  coord_t b_x,
	input  coord_t b_y,
	input  coord_t start_x,
	input  coord_t start_y,
	input  coord_t goal_x,
	input  coord_t goal_y,
	output cost_t  cost_a,
	output cost_t  cost_b
);

	localparam int TERM_W = `COORD_W + 4; //14 x largest step count fits

	typedef logic [TERM_W-1:0] term_t;

	function automatic cost_t octile(input coord_t px, input coord_t py,
		input coord_t qx, input coord_t qy);
		coord_t dx;
		coord_t dy;
		coord_t dmin;
		coord_t dmax;
		term_t diag;
		term_t straight;
		dx = (px > qx) ? px - qx : qx - px;
		dy = (py > qy) ? py - qy : qy - py;
		dmin = (dx < dy) ? dx : dy;
		dmax = (dx < dy) ? dy : dx;
		diag = term_t'(`DIAG_W) * term_t'(dmin);
		straight = term_t'(`STRAIGHT_W) * term_t'(dmax - dmin);
		return cost_t'(diag + straight);
	endfunction

	cost_t total_a;
	cost_t total_b;

	assign total_a = octile(a_x, a_y, start_x, start_y) + octile(a_x, a_y, goal_x, goal_y);
	assign total_b = octile(b_x, b_y, start_x, start_y) + octile(b_x, b_y, goal_x, goal_y);

	always_ff @(posedge Clk or posedge Reset)
	begin
		if (Reset)
		begin
			cost_a <= '0;
			cost_b <= '0;
		end
		else
		begin
			cost_a <= total_a;
			cost_b <= total_b;
		end
	end

endmodule

// File: logic/open_list_sorter.sv
`timescale 1ns/10ps

module open_list_sorter import grid_pkg::*, sort_ctrl_pkg::*;
(
	input  logic   Clk,
	input  logic   Reset,
	input  logic   node_valid,
	input  logic   node_last,
	input  logic   out_credit,
	input  coord_t node_x,
	input  coord_t node_y,
	input  coord_t start_x,
	input  coord_t start_y,
	input  coord_t goal_x,
	input  coord_t goal_y,
	output logic   in_credit,
	output logic   out_valid,
	output logic   out_last,
	output logic   busy,
	output coord_t out_x,
	output coord_t out_y,
	output cost_t  out_cost
);

	count_t len;
	idx_t idx;
	idx_t out_idx;
	logic last_pair;
	logic drain_end;
	cnt_op_t cnt_op;
	logic wr_en;
	logic swap_en;
	logic read_drain;
	coord_t a_x;
	coord_t a_y;
	coord_t b_x;
	coord_t b_y;
	cost_t cost_a;
	cost_t cost_b;
	coord_t start_x_q;
	coord_t start_y_q;
	coord_t goal_x_q;
	coord_t goal_y_q;

	// start and goal ride on the last beat of a batch
	always_ff @(posedge Clk)
	begin
		if (node_valid && node_last)
		begin
			start_x_q <= start_x;
			start_y_q <= start_y;
			goal_x_q <= goal_x;
			goal_y_q <= goal_y;
		end
	end

	//////////////////////////////
	// control
	//////////////////////////////

	sort_fsm u_fsm (
		.Clk        (Clk),
		.Reset      (Reset),
		.node_valid (node_valid),
		.node_last  (node_last),
		.out_credit (out_credit),
		.len        (len),
		.idx        (idx),
		.cost_a     (cost_a),
		.cost_b     (cost_b),
		.last_pair  (last_pair),
		.drain_end  (drain_end),
		.in_credit  (in_credit),
		.wr_en      (wr_en),
		.swap_en    (swap_en),
		.read_drain (read_drain),
		.out_valid  (out_valid),
		.out_last   (out_last),
		.busy       (busy),
		.cnt_op     (cnt_op)
	);

	index_counter u_cnt (
		.Clk       (Clk),
		.Reset     (Reset),
		.op        (cnt_op),
		.len       (len),
		.idx       (idx),
		.out_idx   (out_idx),
		.last_pair (last_pair),
		.drain_end (drain_end)
	);

	//////////////////////////////
	// datapath
	//////////////////////////////

	open_list_ram u_ram (
		.Clk        (Clk),
		.Reset      (Reset),
		.wr_en      (wr_en),
		.swap_en    (swap_en),
		.read_drain (read_drain),
		.wr_idx     (idx_t'(len)), //next free slot
		.pair_idx   (idx),
		.out_idx    (out_idx),
		.wr_x       (node_x),
		.wr_y       (node_y),
		.a_x        (a_x),
		.a_y        (a_y),
		.b_x        (b_x),
		.b_y        (b_y),
		.rd_x       (out_x),
		.rd_y       (out_y)
	);

	octile_cost u_cost (
		.Clk     (Clk),
		.Reset   (Reset),
		.a_x     (a_x),
		.a_y     (a_y),
		.b_x     (b_x),
		.b_y     (b_y),
		.start_x (start_x_q),
		.start_y (start_y_q),
		.goal_x  (goal_x_q),
		.goal_y  (goal_y_q),
		.cost_a  (cost_a),
		.cost_b  (cost_b)
	);

	assign out_cost = cost_a; //port a scores the drain entry

endmodule

// File: testbench/tb_clock_gen.sv
`timescale 1ns/10ps

module tb_clock_gen
#(
	parameter realtime PERIOD = 8.0,
	parameter int RESET_CYCLES = 16
)
(
	output logic Clk,
	output logic Reset
);

	initial
	begin
		Clk = 1'b0;
		forever
			#(PERIOD / 2) Clk = ~Clk;
	end

	initial
	begin
		Reset = 1'b1;
		repeat (RESET_CYCLES)
			@(posedge Clk);
		Reset <= 1'b0; //release on an edge
	end

endmodule

// File: testbench/tb_open_list_sorter.sv
`timescale 1ns/10ps
`include "sort_settings.svh"

module tb_open_list_sorter import grid_pkg::*;
();

	localparam int unsigned SEED = 59;
	localparam int HOLD_CYCLES = 40;
	localparam int NUM_BATCHES = 6;
	localparam int BATCH_CYCLES = 2 * `OPEN_DEPTH //load with credit gaps
		+ `OPEN_DEPTH * `OPEN_DEPTH * 4 //worst case sort
		+ `OPEN_DEPTH * 8 + HOLD_CYCLES; //drain with stalls
	localparam int CYCLE_LIMIT = NUM_BATCHES * BATCH_CYCLES + 200;

	logic Clk;
	logic Reset;
	logic node_valid;
	logic node_last;
	logic out_credit;
	coord_t node_x;
	coord_t node_y;
	coord_t start_x;
	coord_t start_y;
	coord_t goal_x;
	coord_t goal_y;
	logic in_credit;
	logic out_valid;
	logic out_last;
	logic busy;
	coord_t out_x;
	coord_t out_y;
	cost_t out_cost;

	int unsigned stim_seed = SEED;
	int unsigned credit_seed = SEED;
	int pulses_seen = 0; //in_credit pulses so far
	int beats_sent = 0;
	int list_fill = 0; //beats of the current batch in the list
	int out_avail = `OUT_CREDITS; //mirror of the DUT's out credits
	int pending_ret = 0; //credits still owed to the DUT
	int rx_count = 0;
	int exp_n = 0;
	int mismatch_count = 0;
	int fault_count = 0;
	int cycle_count;
	logic in_batch = 1'b0;
	logic quiet = 1'b0; //sort or drain under way
	logic batch_done = 1'b0;
	logic withhold = 1'b0;
	coord_t ends_sx;
	coord_t ends_sy;
	coord_t ends_gx;
	coord_t ends_gy;
	coord_t batch_x [`OPEN_DEPTH];
	coord_t batch_y [`OPEN_DEPTH];
	coord_t exp_x [`OPEN_DEPTH];
	coord_t exp_y [`OPEN_DEPTH];
	cost_t exp_cost [`OPEN_DEPTH];
	int dup_x [8] = '{60, 70, 60, 50, 60, 60, 40, 80}; //repeats and mirror images
	int dup_y [8] = '{30, 40, 40, 40, 50, 40, 40, 40};

	tb_clock_gen #(.PERIOD(8.0), .RESET_CYCLES(16)) u_clk_gen (
		.Clk   (Clk),
		.Reset (Reset)
	);

	open_list_sorter UUT (
		.Clk        (Clk),
		.Reset      (Reset),
		.node_valid (node_valid),
		.node_last  (node_last),
		.out_credit (out_credit),
		.node_x     (node_x),
		.node_y     (node_y),
		.start_x    (start_x),
		.start_y    (start_y),
		.goal_x     (goal_x),
		.goal_y     (goal_y),
		.in_credit  (in_credit),
		.out_valid  (out_valid),
		.out_last   (out_last),
		.busy       (busy),
		.out_x      (out_x),
		.out_y      (out_y),
		.out_cost   (out_cost)
	);

	//////////////////////////////
	// random numbers and model
	//////////////////////////////

	function automatic int unsigned lcg_step(input int unsigned s);
		return s * 32'd1103515245 + 32'd12345;
	endfunction

	function automatic coord_t rand_coord();
		stim_seed = lcg_step(stim_seed);
		return stim_seed[23:16];
	endfunction

	function automatic int octile_ref(input int ax, input int ay, input int bx, input int by);
		int dx;
		int dy;
		int lo;
		int hi;
		dx = (ax > bx) ? ax - bx : bx - ax;
		dy = (ay > by) ? ay - by : by - ay;
		lo = (dx < dy) ? dx : dy;
		hi = (dx < dy) ? dy : dx;
		return `STRAIGHT_W * (hi - lo) + `DIAG_W * lo;
	endfunction

	// stable insertion sort, equal costs keep load order
	task automatic build_model(input int n);
		int i;
		int j;
		int c;
		cost_t tc;
		for (i = 0; i < n; i++)
		begin
			c = octile_ref(batch_x[i], batch_y[i], ends_sx, ends_sy)
				+ octile_ref(batch_x[i], batch_y[i], ends_gx, ends_gy);
			tc = cost_t'(c);
			j = i;
			while ((j > 0) && (exp_cost[j-1] > tc))
			begin
				exp_x[j] = exp_x[j-1];
				exp_y[j] = exp_y[j-1];
				exp_cost[j] = exp_cost[j-1];
				j = j - 1;
			end
			exp_x[j] = batch_x[i];
			exp_y[j] = batch_y[i];
			exp_cost[j] = tc;
		end
		exp_n = n;
	endtask

	//////////////////////////////
	// checks
	//////////////////////////////

	task automatic check_coord(input string what, input coord_t got, input coord_t want);
		if (got !== want)
		begin
			mismatch_count = mismatch_count + 1;
			$display("mismatch at %0t: %s is %0d, expected %0d", $time, what, got, want);
		end
	endtask

	task automatic check_cost(input string what, input cost_t got, input cost_t want);
		if (got !== want)
		begin
			mismatch_count = mismatch_count + 1;
			$display("mismatch at %0t: %s is %0d, expected %0d", $time, what, got, want);
		end
	endtask

	task automatic check_flag(input string what, input logic got, input logic want);
		if (got !== want)
		begin
			mismatch_count = mismatch_count + 1;
			$display("mismatch at %0t: %s is %b, expected %b", $time, what, got, want);
		end
	endtask

	task automatic report_failure(input string what);
		fault_count = fault_count + 1;
		$display("error at %0t: %s", $time, what);
	endtask

	//////////////////////////////
	// monitor, sampled mid cycle
	//////////////////////////////

	always @(negedge Clk)
	begin
		if (Reset)
		begin
			if (in_credit || out_valid || out_last || busy)
				report_failure("outputs not low during reset");
		end
		else
		begin
			if (in_credit)
			begin
				pulses_seen = pulses_seen + 1;
				if (quiet)
					report_failure("in_credit pulse during sort or drain");
			end
			if (pulses_seen - beats_sent + list_fill > `OPEN_DEPTH)
				report_failure("input credits exceed the free list entries");
			check_flag("busy", busy, in_batch);
			if (out_valid)
			begin
				if (out_avail == 0)
					report_failure("out_valid with no downstream credit");
				else
					out_avail = out_avail - 1;
				pending_ret = pending_ret + 1;
				if (rx_count >= exp_n)
					report_failure("out_valid with no entry left in the batch");
				else
				begin
					check_coord("out_x", out_x, exp_x[rx_count]);
					check_coord("out_y", out_y, exp_y[rx_count]);
					check_cost("out_cost", out_cost, exp_cost[rx_count]);
					check_flag("out_last", out_last, rx_count == exp_n - 1);
					rx_count = rx_count + 1;
				end
				if (out_last)
				begin
					batch_done = 1'b1;
					in_batch = 1'b0;
					quiet = 1'b0;
					list_fill = 0;
				end
			end
			else if (out_last)
				report_failure("out_last without out_valid");
			if (out_credit)
				out_avail = out_avail + 1;
		end
	end

	// downstream returns credits at random unless held back
	always @(posedge Clk)
	begin
		credit_seed = lcg_step(credit_seed);
		if (!withhold && (pending_ret > 0) && credit_seed[20])
		begin
			out_credit <= 1'b1;
			pending_ret = pending_ret - 1;
		end
		else
			out_credit <= 1'b0;
	end

	//////////////////////////////
	// stimulus
	//////////////////////////////

	task automatic fill_random(input int n);
		int i;
		for (i = 0; i < n; i++)
		begin
			batch_x[i] = rand_coord();
			batch_y[i] = rand_coord();
		end
		ends_sx = rand_coord();
		ends_sy = rand_coord();
		ends_gx = rand_coord();
		ends_gy = rand_coord();
	endtask

	task automatic load_duplicates();
		int i;
		for (i = 0; i < 8; i++)
		begin
			batch_x[i] = coord_t'(dup_x[i]);
			batch_y[i] = coord_t'(dup_y[i]);
		end
		ends_sx = 8'd40;
		ends_sy = 8'd40;
		ends_gx = 8'd80;
		ends_gy = 8'd40;
	endtask

	task automatic send_batch(input int n);
		int sent;
		logic gap;
		sent = 0;
		while (sent < n)
		begin
			@(posedge Clk);
			gap = (rand_coord() < 8'd64); //about one beat in four held back
			if ((pulses_seen - beats_sent > 0) && !gap)
			begin
				node_valid <= 1'b1;
				node_last <= (sent == n - 1);
				node_x <= batch_x[sent];
				node_y <= batch_y[sent];
				if (sent == n - 1)
				begin
					start_x <= ends_sx;
					start_y <= ends_sy;
					goal_x <= ends_gx;
					goal_y <= ends_gy;
				end
				else
				begin
					start_x <= rand_coord(); //ignored off the last beat
					goal_y <= rand_coord();
				end
				beats_sent = beats_sent + 1;
				list_fill = list_fill + 1;
				sent = sent + 1;
				in_batch = 1'b1;
			end
			else
			begin
				node_valid <= 1'b0;
				node_last <= 1'b0;
			end
		end
		@(posedge Clk);
		node_valid <= 1'b0;
		node_last <= 1'b0;
		quiet = 1'b1;
	endtask

	task automatic run_batch(input int n, input logic hold);
		build_model(n);
		rx_count = 0;
		batch_done = 1'b0;
		withhold = hold;
		send_batch(n);
		if (hold)
		begin
			while (rx_count < `OUT_CREDITS)
				@(negedge Clk);
			repeat (HOLD_CYCLES)
				@(negedge Clk);
			if (rx_count != `OUT_CREDITS)
				report_failure("output went on with downstream credits withheld");
			withhold = 1'b0;
		end
		while (!batch_done)
			@(negedge Clk);
		if (rx_count != n)
			report_failure("batch ended with entries missing");
		while (out_avail != `OUT_CREDITS)
			@(negedge Clk); //all downstream credits home
	endtask

	initial
	begin
		node_valid = 1'b0;
		node_last = 1'b0;
		out_credit = 1'b0;
		node_x = '0;
		node_y = '0;
		start_x = '0;
		start_y = '0;
		goal_x = '0;
		goal_y = '0;
		while (Reset !== 1'b0)
			@(negedge Clk);
		while (pulses_seen < `OPEN_DEPTH)
			@(negedge Clk);
		repeat (8)
			@(negedge Clk);
		if (pulses_seen != `OPEN_DEPTH)
			report_failure("wrong number of input credits after reset");

		fill_random(`OPEN_DEPTH); //full list
		run_batch(`OPEN_DEPTH, 1'b0);
		fill_random(1);
		run_batch(1, 1'b0);
		fill_random(5);
		run_batch(5, 1'b0);
		load_duplicates(); //ties keep load order
		run_batch(8, 1'b0);
		fill_random(`OPEN_DEPTH); //stall in drain
		run_batch(`OPEN_DEPTH, 1'b1);
		fill_random(12);
		run_batch(12, 1'b0);

		repeat (2)
			@(negedge Clk);
		if (busy)
			report_failure("busy still high after the last entry");
		$display("errors: %0d mismatches, %0d other failures", mismatch_count, fault_count);
		if ((mismatch_count == 0) && (fault_count == 0))
			$display("test passed");
		else
			$display("test failed");
		$finish;
	end

	initial
	begin
		cycle_count = 0;
		while (cycle_count < CYCLE_LIMIT)
		begin
			@(posedge Clk);
			cycle_count = cycle_count + 1;
		end
		$display("timeout: run not finished after %0d cycles", CYCLE_LIMIT);
		$display("errors: %0d mismatches, %0d other failures", mismatch_count, fault_count);
		$display("test failed");
		$finish;
	end

endmodule

// File: verilog.f
+incdir+logic
logic/grid_pkg.sv
logic/sort_ctrl_pkg.sv
logic/sort_fsm.sv
logic/index_counter.sv
logic/open_list_ram.sv
logic/octile_cost.sv
logic/open_list_sorter.sv
testbench/tb_clock_gen.sv
testbench/tb_open_list_sorter.sv

// File: Bender.yml
package:
  name: open_list_sorter

sources:
  - include_dirs:
      - logic
    files:
      - logic/grid_pkg.sv
      - logic/sort_ctrl_pkg.sv
      - logic/sort_fsm.sv
      - logic/index_counter.sv
      - logic/open_list_ram.sv
      - logic/octile_cost.sv
      - logic/open_list_sorter.sv
  - target: test
    include_dirs:
      - logic
    files:
      - testbench/tb_clock_gen.sv
      - testbench/tb_open_list_sorter.sv
